// File: lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Address and data widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32

// Instruction tag width
`define LSU_TAG_W 4

// Queue depth and its index width
`define LSU_DEPTH 4
`define LSU_IDX_W 2

`endif

// File: lsu_pkg.sv
`include "lsu_defines.svh"

package lsu_pkg;

  // Basic words
  typedef logic [`LSU_ADDR_W-1:0] lsu_addr_t;
  typedef logic [`LSU_DATA_W-1:0] lsu_data_t;
  typedef logic [`LSU_TAG_W-1:0]  lsu_tag_t;
  typedef logic [`LSU_IDX_W-1:0]  lsu_idx_t;

  // ------------------------------
  // One queue slot
  // ------------------------------
  typedef struct packed {
    // Slot allocated
    logic      valid;
    // Address and data captured
    logic      resolved;
    // Sent to L1 or forwarded
    logic      issued;
    // Result waiting to be reported
    logic      done;
    logic      is_store;
    lsu_tag_t  tag;
    lsu_addr_t addr;
    // Store data, or load result once done
    lsu_data_t value;
  } lsu_entry_t;

  // Whole queue, indexed by slot
  typedef lsu_entry_t [`LSU_DEPTH-1:0] lsu_entry_arr_t;

endpackage

// File: lsu_if.sv
`timescale 1ns/1ps

// Controller to entry storage
interface lsu_entry_if;
  logic                    alloc;
  lsu_pkg::lsu_idx_t       alloc_idx;
  lsu_pkg::lsu_tag_t       alloc_tag;
  logic                    alloc_is_store;
  logic                    issue;
  lsu_pkg::lsu_idx_t       issue_idx;
  logic                    result;
  lsu_pkg::lsu_idx_t       result_idx;
  lsu_pkg::lsu_data_t      result_value;
  logic                    free;
  lsu_pkg::lsu_idx_t       free_idx;
  lsu_pkg::lsu_entry_arr_t entries;
  logic                    any_unresolved;

  modport ctrl (
    output alloc, alloc_idx, alloc_tag, alloc_is_store,
    output issue, issue_idx, result, result_idx, result_value,
    output free, free_idx,
    input  entries, any_unresolved
  );

  modport file (
    input  alloc, alloc_idx, alloc_tag, alloc_is_store,
    input  issue, issue_idx, result, result_idx, result_value,
    input  free, free_idx,
    output entries, any_unresolved
  );
endinterface

// Controller to L1 sequencer, four-phase req/ack
interface lsu_mem_if;
  logic               req;
  logic               is_store;
  lsu_pkg::lsu_addr_t addr;
  lsu_pkg::lsu_data_t wdata;
  // Slot that owns the access, kept by the controller
  lsu_pkg::lsu_idx_t  slot;
  logic               ack;
  lsu_pkg::lsu_data_t rdata;

  modport ctrl (output req, is_store, addr, wdata, slot, input ack, rdata);
  modport port (input req, is_store, addr, wdata, output ack, rdata);
endinterface

// File: lsu_entry_file.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_entry_file (
  input  logic               clk_in,
  input  logic               rst_N_in,
  input  logic               data_valid,
  input  lsu_pkg::lsu_tag_t  data_tag,
  input  lsu_pkg::lsu_addr_t data_addr,
  input  lsu_pkg::lsu_data_t data_value,
  lsu_entry_if.file          ent
);

  lsu_pkg::lsu_entry_arr_t q;

  // ------------------------------
  // Slot updates
  // ------------------------------
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      // Only the status bits are cleared
      for (int i = 0; i < `LSU_DEPTH; i++) begin
        q[i].valid    <= 1'b0;
        q[i].resolved <= 1'b0;
        q[i].issued   <= 1'b0;
        q[i].done     <= 1'b0;
      end
    end else begin
      // Operand capture, tag match on waiting slots
      for (int i = 0; i < `LSU_DEPTH; i++) begin
        if (data_valid && q[i].valid && !q[i].resolved && (q[i].tag == data_tag)) begin
          q[i].resolved <= 1'b1;
          q[i].addr     <= data_addr;
          // Loads get their value later
          if (q[i].is_store) begin
            q[i].value <= data_value;
          end
        end
      end

      // New instruction at the tail
      if (ent.alloc) begin
        q[ent.alloc_idx].valid    <= 1'b1;
        q[ent.alloc_idx].resolved <= 1'b0;
        q[ent.alloc_idx].issued   <= 1'b0;
        q[ent.alloc_idx].done     <= 1'b0;
        q[ent.alloc_idx].is_store <= ent.alloc_is_store;
        q[ent.alloc_idx].tag      <= ent.alloc_tag;
      end

      if (ent.issue) begin
        q[ent.issue_idx].issued <= 1'b1;
      end

      // Store data stays, younger loads may still forward from it
      if (ent.result) begin
        q[ent.result_idx].done <= 1'b1;
        if (!q[ent.result_idx].is_store) begin
          q[ent.result_idx].value <= ent.result_value;
        end
      end

      // Reported, slot waits for head retirement
      if (ent.free) begin
        q[ent.free_idx].valid <= 1'b0;
      end
    end
  end

  // Some slot still waits for operands
  always_comb begin
    ent.any_unresolved = 1'b0;
    for (int i = 0; i < `LSU_DEPTH; i++) begin
      if (q[i].valid && !q[i].resolved) begin
        ent.any_unresolved = 1'b1;
      end
    end
  end

  assign ent.entries = q;

endmodule

// File: lsu_store_forward.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_store_forward (
  input  lsu_pkg::lsu_entry_arr_t entries,
  input  lsu_pkg::lsu_idx_t       head,
  input  lsu_pkg::lsu_idx_t       load_idx,
  output logic                    hit,
  output lsu_pkg::lsu_data_t      fwd_value
);

  // Walk oldest to youngest up to the load
  // A later match overrides, so the youngest older store wins
  always_comb begin
    lsu_pkg::lsu_idx_t idx;
    logic              older;
    hit       = 1'b0;
    fwd_value = '0;
    older     = 1'b1;
    for (int k = 0; k < `LSU_DEPTH; k++) begin
      idx = head + lsu_pkg::lsu_idx_t'(k);
      // Reached the load itself
      if (idx == load_idx) begin
        older = 1'b0;
      end
      if (older && entries[idx].valid && entries[idx].is_store &&
          entries[idx].resolved && (entries[idx].addr == entries[load_idx].addr)) begin
        hit       = 1'b1;
        fwd_value = entries[idx].value;
      end
    end
  end

endmodule

// File: lsu_l1d_port.sv
`timescale 1ns/1ps

module lsu_l1d_port (
  input  logic               clk_in,
  input  logic               rst_N_in,
  lsu_mem_if.port            mem,
  output logic               l1d_req,
  output logic               l1d_we,
  output lsu_pkg::lsu_addr_t l1d_addr,
  output lsu_pkg::lsu_data_t l1d_wdata,
  input  logic               l1d_ack,
  input  lsu_pkg::lsu_data_t l1d_rdata
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_REL
  } state_t;

  state_t state;

  // ------------------------------
  // Handshake sequencer
  // ------------------------------
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state   <= ST_IDLE;
      l1d_req <= 1'b0;
      mem.ack <= 1'b0;
    end else begin
      case (state)
        // ack is low here, so a req is a new access
        ST_IDLE: begin
          if (mem.req) begin
            l1d_req <= 1'b1;
            state   <= ST_REQ;
          end
        end
        // Hold the request until the L1 answers
        ST_REQ: begin
          if (l1d_ack) begin
            mem.ack <= 1'b1;
            state   <= ST_REL;
          end
        end
        // Follow the controller release, then wait for L1 ack to drop
        ST_REL: begin
          if (!mem.req) begin
            l1d_req <= 1'b0;
          end
          if (!l1d_req && !l1d_ack) begin
            mem.ack <= 1'b0;
            state   <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Request fields and read data
  always_ff @(posedge clk_in) begin
    if ((state == ST_IDLE) && mem.req) begin
      l1d_we    <= mem.is_store;
      l1d_addr  <= mem.addr;
      l1d_wdata <= mem.wdata;
    end
    // Sample on the first ack only
    if ((state == ST_REQ) && l1d_ack) begin
      mem.rdata <= l1d_rdata;
    end
  end

endmodule

// File: lsu_queue_ctrl.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_queue_ctrl (
  input  logic               clk_in,
  input  logic               rst_N_in,
  input  logic               instr_valid,
  input  lsu_pkg::lsu_tag_t  instr_tag,
  input  logic               instr_is_store,
  output logic               instr_ready,
  output logic               data_ready,
  lsu_entry_if.ctrl          ent,
  lsu_mem_if.ctrl            mem,
  output logic               completion_valid,
  output lsu_pkg::lsu_tag_t  completion_tag,
  output lsu_pkg::lsu_data_t completion_value
);

  lsu_pkg::lsu_idx_t     head;
  lsu_pkg::lsu_idx_t     tail;
  logic [`LSU_IDX_W:0]   count;
  logic                  accept;
  logic                  retire;
  logic                  mem_idle;
  logic                  mem_done;
  logic                  mem_go;
  logic [`LSU_DEPTH-1:0] fwd_hit;
  lsu_pkg::lsu_data_t    fwd_val [`LSU_DEPTH];
  logic                  ld_found;
  logic                  ld_fwd;
  lsu_pkg::lsu_idx_t     ld_idx;
  logic                  st_found;
  lsu_pkg::lsu_idx_t     st_idx;
  logic                  cmp_found;
  lsu_pkg::lsu_idx_t     cmp_idx;

  assign accept      = instr_valid && instr_ready;
  assign instr_ready = (count != (`LSU_IDX_W+1)'(`LSU_DEPTH));
  assign data_ready  = ent.any_unresolved;
  // Head slot freed after reporting
  assign retire      = (count != '0) && !ent.entries[head].valid;
  assign mem_idle    = !mem.req && !mem.ack;
  // First ack of the outstanding access
  assign mem_done    = mem.req && mem.ack;

  // One forward search per slot
  for (genvar g = 0; g < `LSU_DEPTH; g++) begin : g_fwd
    lsu_store_forward u_fwd (
      .entries   (ent.entries),
      .head      (head),
      .load_idx  (lsu_pkg::lsu_idx_t'(g)),
      .hit       (fwd_hit[g]),
      .fwd_value (fwd_val[g])
    );
  end

  // ------------------------------
  // Oldest-first scan
  // ------------------------------
  always_comb begin
    lsu_pkg::lsu_idx_t   idx;
    lsu_pkg::lsu_entry_t e;
    logic                st_unres;
    logic                unissued;
    ld_found  = 1'b0;
    ld_fwd    = 1'b0;
    ld_idx    = '0;
    st_found  = 1'b0;
    st_idx    = '0;
    cmp_found = 1'b0;
    cmp_idx   = '0;
    st_unres  = 1'b0;
    unissued  = 1'b0;
    for (int k = 0; k < `LSU_DEPTH; k++) begin
      idx = head + lsu_pkg::lsu_idx_t'(k);
      e   = ent.entries[idx];
      if (e.valid) begin
        // Load, all older stores known; forwardable loads skip a busy L1
        if (!e.is_store && e.resolved && !e.issued && !st_unres && !ld_found &&
            ((fwd_hit[idx] && !mem_done) || mem_idle)) begin
          ld_found = 1'b1;
          ld_fwd   = fwd_hit[idx];
          ld_idx   = idx;
        end
        // Store goes only once everything older has issued
        if (e.is_store && e.resolved && !e.issued && !unissued && !st_found) begin
          st_found = 1'b1;
          st_idx   = idx;
        end
        if (e.is_store && !e.resolved) begin
          st_unres = 1'b1;
        end
        if (!e.issued) begin
          unissued = 1'b1;
        end
        if (e.done && !cmp_found) begin
          cmp_found = 1'b1;
          cmp_idx   = idx;
        end
      end
    end
  end

  // ------------------------------
  // Entry commands
  // ------------------------------
  always_comb begin
    ent.alloc          = accept;
    ent.alloc_idx      = tail;
    ent.alloc_tag      = instr_tag;
    ent.alloc_is_store = instr_is_store;
    ent.issue          = ld_found || (st_found && mem_idle);
    ent.issue_idx      = ld_found ? ld_idx : st_idx;
    mem_go             = ent.issue && !(ld_found && ld_fwd);
    // Forward completes in place; an L1 result never collides with it
    ent.result         = ld_found && ld_fwd;
    ent.result_idx     = ld_idx;
    ent.result_value   = fwd_val[ld_idx];
    if (mem_done) begin
      ent.result       = 1'b1;
      ent.result_idx   = mem.slot;
      ent.result_value = mem.rdata;
    end
    ent.free           = cmp_found;
    ent.free_idx       = cmp_idx;
  end

  // L1 request, raised on issue and dropped on ack
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      mem.req <= 1'b0;
    end else if (mem_go) begin
      mem.req <= 1'b1;
    end else if (mem_done) begin
      mem.req <= 1'b0;
    end
  end

  always_ff @(posedge clk_in) begin
    if (mem_go) begin
      mem.is_store <= ent.entries[ent.issue_idx].is_store;
      mem.addr     <= ent.entries[ent.issue_idx].addr;
      mem.wdata    <= ent.entries[ent.issue_idx].value;
      mem.slot     <= ent.issue_idx;
    end
  end

  // Completion, stores report zero
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      completion_valid <= 1'b0;
    end else begin
      completion_valid <= cmp_found;
    end
  end

  always_ff @(posedge clk_in) begin
    if (cmp_found) begin
      completion_tag   <= ent.entries[cmp_idx].tag;
      completion_value <= ent.entries[cmp_idx].is_store ? '0 : ent.entries[cmp_idx].value;
    end
  end

  // Ring pointers
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (accept) begin
        tail <= tail + 1'b1;
      end
      if (retire) begin
        head <= head + 1'b1;
      end
      count <= count + (`LSU_IDX_W+1)'(accept) - (`LSU_IDX_W+1)'(retire);
    end
  end

endmodule

// File: lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
  input  logic               clk_in,
  input  logic               rst_N_in,
  // Instructions in program order
  input  logic               instr_valid,
  output logic               instr_ready,
  input  lsu_pkg::lsu_tag_t  instr_tag,
  input  logic               instr_is_store,
  // Operands by tag
  input  logic               data_valid,
  output logic               data_ready,
  input  lsu_pkg::lsu_tag_t  data_tag,
  input  lsu_pkg::lsu_addr_t data_addr,
  input  lsu_pkg::lsu_data_t data_value,
  // L1 data cache
  output logic               l1d_req,
  input  logic               l1d_ack,
  output logic               l1d_we,
  output lsu_pkg::lsu_addr_t l1d_addr,
  output lsu_pkg::lsu_data_t l1d_wdata,
  input  lsu_pkg::lsu_data_t l1d_rdata,
  // Results
  output logic               completion_valid,
  output lsu_pkg::lsu_tag_t  completion_tag,
  output lsu_pkg::lsu_data_t completion_value
);

  lsu_entry_if u_ent_if ();
  lsu_mem_if   u_mem_if ();

  lsu_entry_file u_entry_file (
    .clk_in     (clk_in),
    .rst_N_in   (rst_N_in),
    .data_valid (data_valid),
    .data_tag   (data_tag),
    .data_addr  (data_addr),
    .data_value (data_value),
    .ent        (u_ent_if.file)
  );

  lsu_queue_ctrl u_queue_ctrl (
    .clk_in           (clk_in),
    .rst_N_in         (rst_N_in),
    .instr_valid      (instr_valid),
    .instr_tag        (instr_tag),
    .instr_is_store   (instr_is_store),
    .instr_ready      (instr_ready),
    .data_ready       (data_ready),
    .ent              (u_ent_if.ctrl),
    .mem              (u_mem_if.ctrl),
    .completion_valid (completion_valid),
    .completion_tag   (completion_tag),
    .completion_value (completion_value)
  );

  lsu_l1d_port u_l1d_port (
    .clk_in    (clk_in),
    .rst_N_in  (rst_N_in),
    .mem       (u_mem_if.port),
    .l1d_req   (l1d_req),
    .l1d_we    (l1d_we),
    .l1d_addr  (l1d_addr),
    .l1d_wdata (l1d_wdata),
    .l1d_ack   (l1d_ack),
    .l1d_rdata (l1d_rdata)
  );

endmodule

// File: lsu_sva.sv
`timescale 1ns/1ps

module lsu_sva (
  input logic               clk_in,
  input logic               rst_N_in,
  input logic               req,
  input logic               ack,
  input logic               l1d_req,
  input logic               l1d_we,
  input lsu_pkg::lsu_addr_t l1d_addr,
  input lsu_pkg::lsu_data_t l1d_wdata,
  input logic               l1d_ack
);

  // Assertion failures seen so far
  int assert_fails = 0;

  // ------------------------------
  // L1 side four-phase rules
  // ------------------------------
  // Request and its fields hold until the L1 answers and write data matters only for stores
  a_req_hold: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    (l1d_req && !l1d_ack) |=> (l1d_req && $stable(l1d_we) && $stable(l1d_addr) &&
                               (!l1d_we || $stable(l1d_wdata))))
    else begin
      assert_fails++;
      $error("l1d_req dropped or changed before l1d_ack");
    end

  // New access only after the previous ack is gone
  a_no_rise_on_ack: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    $rose(l1d_req) |-> !$past(l1d_ack))
    else begin
      assert_fails++;
      $error("l1d_req rose while l1d_ack was high");
    end

  // Controller side ack follows a live req
  a_ack_needs_req: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    $rose(ack) |-> req)
    else begin
      assert_fails++;
      $error("ack rose without req");
    end

endmodule

bind lsu_l1d_port lsu_sva u_sva (
  .clk_in    (clk_in),
  .rst_N_in  (rst_N_in),
  .req       (mem.req),
  .ack       (mem.ack),
  .l1d_req   (l1d_req),
  .l1d_we    (l1d_we),
  .l1d_addr  (l1d_addr),
  .l1d_wdata (l1d_wdata),
  .l1d_ack   (l1d_ack)
);

// File: lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

  localparam int unsigned SEED           = 74305;
  localparam int          TIMEOUT_CYCLES = 2000;
  localparam int          PROG_MAX       = 512;
  localparam int          RANDOM_LEN     = 200;
  localparam int          ORDER_LEN      = 24;
  // Eight word addresses shared by the random streams
  localparam logic [31:0] ADDR_BASE      = 32'h0000_0100;
  // Unwritten L1 words read as address XOR this
  localparam logic [31:0] INIT_KEY       = 32'h5A3C_96E1;

  logic               clk_in;
  logic               rst_N_in;
  logic               instr_valid;
  logic               instr_ready;
  lsu_pkg::lsu_tag_t  instr_tag;
  logic               instr_is_store;
  logic               data_valid;
  logic               data_ready;
  lsu_pkg::lsu_tag_t  data_tag;
  lsu_pkg::lsu_addr_t data_addr;
  lsu_pkg::lsu_data_t data_value;
  logic               l1d_req;
  logic               l1d_ack;
  logic               l1d_we;
  lsu_pkg::lsu_addr_t l1d_addr;
  lsu_pkg::lsu_data_t l1d_wdata;
  lsu_pkg::lsu_data_t l1d_rdata;
  logic               completion_valid;
  lsu_pkg::lsu_tag_t  completion_tag;
  lsu_pkg::lsu_data_t completion_value;

  // Program-order stream indexed by accept order
  logic        prog_store [PROG_MAX];
  logic [31:0] prog_addr  [PROG_MAX];
  logic [31:0] prog_value [PROG_MAX];
  logic        comp_seen  [PROG_MAX];
  logic        req_at_comp[PROG_MAX];
  int          prog_n;

  // Real tags are 0..7 and tags 8..15 never belong to an instruction
  logic        tag_busy [8];
  int          tag_idx  [8];
  int          outstanding;

  int unsigned rng_state;
  int          mismatch_count;
  int          fail_count;
  int          assert_count;

  // L1 model state
  logic [31:0] l1_mem [logic [31:0]];
  logic        l1_stall;
  int          l1_delay;
  logic        last_we;
  logic [31:0] last_addr;

  int          idx_a;
  int          idx_b;

  lsu_top u_lsu_top (
    .clk_in           (clk_in),
    .rst_N_in         (rst_N_in),
    .instr_valid      (instr_valid),
    .instr_ready      (instr_ready),
    .instr_tag        (instr_tag),
    .instr_is_store   (instr_is_store),
    .data_valid       (data_valid),
    .data_ready       (data_ready),
    .data_tag         (data_tag),
    .data_addr        (data_addr),
    .data_value       (data_value),
    .l1d_req          (l1d_req),
    .l1d_ack          (l1d_ack),
    .l1d_we           (l1d_we),
    .l1d_addr         (l1d_addr),
    .l1d_wdata        (l1d_wdata),
    .l1d_rdata        (l1d_rdata),
    .completion_valid (completion_valid),
    .completion_tag   (completion_tag),
    .completion_value (completion_value)
  );

  // 40 ns period
  always #20 clk_in = ~clk_in;

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic int unsigned xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'(xorshift32() % n);
  endfunction

  function automatic logic [31:0] init_word(input logic [31:0] addr);
    return addr ^ INIT_KEY;
  endfunction

  // Expected completion from a replay of the stream before idx
  function automatic logic [31:0] ref_value(input int idx);
    logic [31:0] v;
    if (prog_store[idx]) begin
      return 32'h0;
    end
    v = init_word(prog_addr[idx]);
    for (int j = 0; j < idx; j++) begin
      if (prog_store[j] && (prog_addr[j] == prog_addr[idx])) begin
        v = prog_value[j];
      end
    end
    return v;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    fail_count++;
    $display("Timeout at %0t while waiting for %s", $time, what);
  endtask

  // Appends n instructions with store_pct percent stores
  task automatic make_program(input int n, input int store_pct);
    for (int i = 0; i < n; i++) begin
      prog_store[prog_n]  = (rand_below(100) < store_pct);
      prog_addr[prog_n]   = ADDR_BASE + 32'(4 * rand_below(8));
      prog_value[prog_n]  = xorshift32();
      comp_seen[prog_n]   = 1'b0;
      req_at_comp[prog_n] = 1'b0;
      prog_n++;
    end
  endtask

  // Accepted at the coming edge once the caller has seen instr_ready high
  task automatic drive_instr(input int idx);
    instr_valid    = 1'b1;
    instr_tag      = lsu_pkg::lsu_tag_t'(idx % 8);
    instr_is_store = prog_store[idx];
    tag_idx[idx % 8]  = idx;
    tag_busy[idx % 8] = 1'b1;
    outstanding++;
  endtask

  task automatic drive_operand(input int idx);
    data_valid = 1'b1;
    data_tag   = lsu_pkg::lsu_tag_t'(idx % 8);
    data_addr  = prog_addr[idx];
    data_value = prog_value[idx];
  endtask

  task automatic idle_cycle();
    @(negedge clk_in);
    instr_valid = 1'b0;
    data_valid  = 1'b0;
  endtask

  task automatic offer_instr(input int idx);
    int waited;
    waited = 0;
    idle_cycle();
    while (!instr_ready && (waited < TIMEOUT_CYCLES)) begin
      idle_cycle();
      waited++;
    end
    if (instr_ready) begin
      drive_instr(idx);
    end else begin
      note_timeout("instr_ready");
    end
  endtask

  task automatic offer_operand(input int idx);
    idle_cycle();
    drive_operand(idx);
  endtask

  // Interleaves instructions, operands and stray tags at random
  task automatic drive_range(input int first, input int n, input int unk_pct);
    int pend[$];
    int next;
    int sent;
    int pick;
    int stuck;
    next  = first;
    sent  = 0;
    stuck = 0;
    while ((sent < n) && (stuck < TIMEOUT_CYCLES)) begin
      idle_cycle();
      stuck++;
      // Operands only for slots allocated at an earlier edge
      if ((pend.size() > 0) && (rand_below(4) != 0)) begin
        pick = rand_below(pend.size());
        drive_operand(pend[pick]);
        pend.delete(pick);
        sent++;
        stuck = 0;
      end else if (rand_below(100) < unk_pct) begin
        data_valid = 1'b1;
        data_tag   = lsu_pkg::lsu_tag_t'(8 + rand_below(8));
        data_addr  = xorshift32();
        data_value = xorshift32();
      end
      if ((next < first + n) && instr_ready && (rand_below(4) != 0)) begin
        drive_instr(next);
        pend.push_back(next);
        next++;
        stuck = 0;
      end
    end
    if (sent < n) begin
      note_timeout("stream progress");
    end
    idle_cycle();
  endtask

  task automatic run_stream(input int n, input int store_pct, input int unk_pct);
    int first;
    first = prog_n;
    make_program(n, store_pct);
    drive_range(first, n, unk_pct);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while ((outstanding != 0) && (waited < TIMEOUT_CYCLES)) begin
      idle_cycle();
      waited++;
    end
    if (outstanding != 0) begin
      note_timeout("outstanding completions");
    end
  endtask

  // ------------------------------
  // L1 model
  // ------------------------------
  always @(negedge clk_in) begin
    if (!rst_N_in) begin
      l1d_ack  = 1'b0;
      l1_delay = -1;
    end else if (l1d_req && !l1d_ack) begin
      if (l1_delay < 0) begin
        l1_delay = rand_below(4);
      end
      if (!l1_stall) begin
        if (l1_delay == 0) begin
          last_we   = l1d_we;
          last_addr = l1d_addr;
          if (l1d_we) begin
            l1_mem[l1d_addr] = l1d_wdata;
          end else if (l1_mem.exists(l1d_addr)) begin
            l1d_rdata = l1_mem[l1d_addr];
          end else begin
            l1d_rdata = init_word(l1d_addr);
          end
          l1d_ack  = 1'b1;
          l1_delay = -1;
        end else begin
          l1_delay = l1_delay - 1;
        end
      end
    end else if (!l1d_req && l1d_ack) begin
      l1d_ack = 1'b0;
    end
  end

  // ------------------------------
  // Completion checker
  // ------------------------------
  always @(negedge clk_in) begin : compare_proc
    int idx;
    if (rst_N_in && completion_valid) begin
      if (completion_tag[3] || !tag_busy[completion_tag[2:0]]) begin
        fail_count++;
        $display("Completion at %0t with tag %0d that has no outstanding instruction",
                 $time, completion_tag);
      end else begin
        idx = tag_idx[completion_tag[2:0]];
        check_eq(completion_value, ref_value(idx), $sformatf("completion of #%0d", idx));
        comp_seen[idx]   = 1'b1;
        req_at_comp[idx] = l1d_req;
        tag_busy[completion_tag[2:0]] = 1'b0;
        outstanding--;
      end
    end
  end

  initial begin
    clk_in         = 1'b0;
    rst_N_in       = 1'b0;
    instr_valid    = 1'b0;
    instr_tag      = '0;
    instr_is_store = 1'b0;
    data_valid     = 1'b0;
    data_tag       = '0;
    data_addr      = '0;
    data_value     = '0;
    l1d_ack        = 1'b0;
    l1d_rdata      = '0;
    l1_stall       = 1'b0;
    l1_delay       = -1;
    last_we        = 1'b1;
    last_addr      = '0;
    rng_state      = SEED;
    prog_n         = 0;
    outstanding    = 0;
    mismatch_count = 0;
    fail_count     = 0;
    assert_count   = 0;
    for (int t = 0; t < 8; t++) begin
      tag_busy[t] = 1'b0;
      tag_idx[t]  = 0;
    end

    repeat (16) @(negedge clk_in);
    rst_N_in = 1'b1;

    // Reset values before any stimulus
    @(negedge clk_in);
    check_eq(32'(instr_ready), 32'd1, "instr_ready after reset");
    check_eq(32'(completion_valid), 32'd0, "completion_valid after reset");
    check_eq(32'(data_ready), 32'd0, "data_ready after reset");
    check_eq(32'(l1d_req), 32'd0, "l1d_req after reset");

    // Single load from untouched memory
    make_program(1, 0);
    idx_a = prog_n - 1;
    prog_addr[idx_a] = 32'h0000_8000;
    offer_instr(idx_a);
    idle_cycle();
    check_eq(32'(data_ready), 32'd1, "data_ready with a load awaiting operands");
    drive_operand(idx_a);
    drain();
    check_eq(32'(last_we), 32'd0, "L1 access kind for a load");
    check_eq(last_addr, 32'h0000_8000, "L1 address for a load");

    // Store then load to one address with the L1 held off
    l1_stall = 1'b1;
    make_program(2, 0);
    idx_a = prog_n - 2;
    idx_b = prog_n - 1;
    prog_store[idx_a] = 1'b1;
    prog_addr[idx_b]  = prog_addr[idx_a];
    offer_instr(idx_a);
    offer_instr(idx_b);
    offer_operand(idx_a);
    begin : wait_store_req
      int waited;
      waited = 0;
      idle_cycle();
      while (!l1d_req && (waited < TIMEOUT_CYCLES)) begin
        idle_cycle();
        waited++;
      end
      if (!l1d_req) begin
        note_timeout("store request on L1");
      end
    end
    offer_operand(idx_b);
    begin : wait_fwd
      int waited;
      waited = 0;
      idle_cycle();
      while (!comp_seen[idx_b] && (waited < TIMEOUT_CYCLES)) begin
        idle_cycle();
        waited++;
      end
      if (!comp_seen[idx_b]) begin
        note_timeout("forwarded load completion");
      end
    end
    check_eq(32'(req_at_comp[idx_b]), 32'd1, "l1d_req during forwarded completion");
    check_eq(32'(comp_seen[idx_a]), 32'd0, "store done before L1 release");
    l1_stall = 1'b0;
    drain();

    // Random operand order with stray tags
    run_stream(ORDER_LEN, 50, 30);
    drain();

    // Full queue with the L1 held off
    l1_stall = 1'b1;
    run_stream(4, 0, 0);
    check_eq(32'(instr_ready), 32'd0, "instr_ready with four slots held");
    make_program(1, 0);
    idx_a = prog_n - 1;
    instr_valid    = 1'b1;
    instr_tag      = lsu_pkg::lsu_tag_t'(idx_a % 8);
    instr_is_store = 1'b0;
    repeat (4) begin
      @(negedge clk_in);
      check_eq(32'(instr_ready), 32'd0, "instr_ready while the L1 stalls");
    end
    instr_valid = 1'b0;
    l1_stall    = 1'b0;
    drive_range(idx_a, 1, 0);
    drain();

    // Long mixed stream
    run_stream(RANDOM_LEN, 50, 10);
    drain();

    for (int i = 0; i < prog_n; i++) begin
      if (!comp_seen[i]) begin
        fail_count++;
        $display("Instruction %0d never completed", i);
      end
    end

    assert_count = u_lsu_top.u_l1d_port.u_sva.assert_fails;
    $display("Run finished with %0d mismatches, %0d assertion failures and %0d other errors",
             mismatch_count, assert_count, fail_count);
    if ((mismatch_count == 0) && (fail_count == 0) && (assert_count == 0)) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: lsu.f
+incdir+.
lsu_pkg.sv
lsu_if.sv
lsu_entry_file.sv
lsu_store_forward.sv
lsu_l1d_port.sv
lsu_queue_ctrl.sv
lsu_top.sv
lsu_sva.sv
lsu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= lsu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
